// ==== verilog/kgp_pkg.sv ====
package kgp_pkg;

	////////////////////
	// Word level types
	////////////////////

	typedef logic [31:0] word_t;
	typedef logic [4:0]  reg_addr_t;
	typedef logic [4:0]  shamt_t;

	localparam reg_addr_t link_reg = 5'd31;
	localparam word_t     reset_pc = 32'h0000_0000;

	////////////////////
	// Instruction fields
	////////////////////

	// Primary opcode in instr[31:26]
	typedef enum logic [5:0] {
		op_rtype = 6'h00,
		op_addi  = 6'h01,
		op_compi = 6'h02,
		op_lw    = 6'h03,
		op_sw    = 6'h04,
		op_br    = 6'h05,
		op_b     = 6'h06,
		op_bl    = 6'h07,
		op_bltz  = 6'h08,
		op_bz    = 6'h09,
		op_bnz   = 6'h0a,
		op_bcy   = 6'h0b,
		op_bncy  = 6'h0c
	} opcode_t;

	// Function code in instr[5:0], register class only
	typedef enum logic [5:0] {
		fn_add   = 6'h00,
		fn_comp  = 6'h01,
		fn_and   = 6'h02,
		fn_xor   = 6'h03,
		fn_shll  = 6'h04,
		fn_shrl  = 6'h05,
		fn_shra  = 6'h06,
		fn_shllv = 6'h07,
		fn_shrlv = 6'h08,
		fn_shrav = 6'h09
	} funct_t;

	////////////////////
	// Datapath control
	////////////////////

	typedef enum logic [2:0] {
		alu_add,
		alu_comp,
		alu_and,
		alu_xor,
		alu_shll,
		alu_shrl,
		alu_shra,
		alu_pass_b
	} alu_op_t;

	typedef struct packed {
		logic carry;
		logic zero;
		logic sign;
	} flags_t;

	typedef enum logic [1:0] {
		wb_alu,
		wb_mem,
		wb_link
	} wb_sel_t;

	typedef enum logic [1:0] {
		dest_rs,
		dest_rt,
		dest_r31
	} dest_sel_t;

	typedef enum logic [3:0] {
		br_none,
		br_b,
		br_br,
		br_bl,
		br_bltz,
		br_bz,
		br_bnz,
		br_bcy,
		br_bncy
	} br_kind_t;

	typedef struct packed {
		logic      reg_write;
		logic      mem_read;
		logic      mem_write;
		logic      use_imm;
		logic      shift_by_reg;
		logic      set_carry;
		dest_sel_t dest;
		wb_sel_t   wb;
		alu_op_t   alu_op;
		br_kind_t  br;
		logic      illegal;
	} ctrl_t;

endpackage

// ==== verilog/control_unit.sv ====
`timescale 1ns/100ps

module control_unit (
	input  kgp_pkg::word_t instr,
	output kgp_pkg::ctrl_t ctrl
);

	kgp_pkg::opcode_t opcode;
	kgp_pkg::funct_t  funct;

	assign opcode = kgp_pkg::opcode_t'(instr[31:26]);
	assign funct  = kgp_pkg::funct_t'(instr[5:0]);

	always_comb begin
		// Defaults describe a no-op that falls through to pc + 4
		ctrl.reg_write    = 1'b0;
		ctrl.mem_read     = 1'b0;
		ctrl.mem_write    = 1'b0;
		ctrl.use_imm      = 1'b0;
		ctrl.shift_by_reg = 1'b0;
		ctrl.set_carry    = 1'b0;
		ctrl.dest         = kgp_pkg::dest_rs;
		ctrl.wb           = kgp_pkg::wb_alu;
		ctrl.alu_op       = kgp_pkg::alu_add;
		ctrl.br           = kgp_pkg::br_none;
		ctrl.illegal      = 1'b0;

		case (opcode)
			kgp_pkg::op_rtype: begin
				ctrl.reg_write = 1'b1;
				case (funct)
					kgp_pkg::fn_add: begin
						ctrl.alu_op    = kgp_pkg::alu_add;
						ctrl.set_carry = 1'b1;
					end
					kgp_pkg::fn_comp: begin
						ctrl.alu_op    = kgp_pkg::alu_comp;
						ctrl.set_carry = 1'b1;
					end
					kgp_pkg::fn_and:  ctrl.alu_op = kgp_pkg::alu_and;
					kgp_pkg::fn_xor:  ctrl.alu_op = kgp_pkg::alu_xor;
					kgp_pkg::fn_shll: ctrl.alu_op = kgp_pkg::alu_shll;
					kgp_pkg::fn_shrl: ctrl.alu_op = kgp_pkg::alu_shrl;
					kgp_pkg::fn_shra: ctrl.alu_op = kgp_pkg::alu_shra;
					kgp_pkg::fn_shllv: begin
						ctrl.alu_op       = kgp_pkg::alu_shll;
						ctrl.shift_by_reg = 1'b1;
					end
					kgp_pkg::fn_shrlv: begin
						ctrl.alu_op       = kgp_pkg::alu_shrl;
						ctrl.shift_by_reg = 1'b1;
					end
					kgp_pkg::fn_shrav: begin
						ctrl.alu_op       = kgp_pkg::alu_shra;
						ctrl.shift_by_reg = 1'b1;
					end
					default: begin
						ctrl.reg_write = 1'b0;
						ctrl.illegal   = 1'b1;
					end
				endcase
			end
			kgp_pkg::op_addi: begin
				ctrl.reg_write = 1'b1;
				ctrl.use_imm   = 1'b1;
				ctrl.set_carry = 1'b1;
			end
			kgp_pkg::op_compi: begin
				ctrl.reg_write = 1'b1;
				ctrl.use_imm   = 1'b1;
				ctrl.set_carry = 1'b1;
				ctrl.alu_op    = kgp_pkg::alu_comp;
			end
			// Loads write rt, address is rs + imm
			kgp_pkg::op_lw: begin
				ctrl.reg_write = 1'b1;
				ctrl.mem_read  = 1'b1;
				ctrl.use_imm   = 1'b1;
				ctrl.dest      = kgp_pkg::dest_rt;
				ctrl.wb        = kgp_pkg::wb_mem;
			end
			kgp_pkg::op_sw: begin
				ctrl.mem_write = 1'b1;
				ctrl.use_imm   = 1'b1;
			end
			kgp_pkg::op_br: ctrl.br = kgp_pkg::br_br;
			kgp_pkg::op_b:  ctrl.br = kgp_pkg::br_b;
			kgp_pkg::op_bl: begin
				ctrl.br        = kgp_pkg::br_bl;
				ctrl.reg_write = 1'b1;
				ctrl.dest      = kgp_pkg::dest_r31;
				ctrl.wb        = kgp_pkg::wb_link;
			end
			// rs goes through the ALU so its flags decide the branch
			kgp_pkg::op_bltz: begin
				ctrl.br     = kgp_pkg::br_bltz;
				ctrl.alu_op = kgp_pkg::alu_pass_b;
			end
			kgp_pkg::op_bz: begin
				ctrl.br     = kgp_pkg::br_bz;
				ctrl.alu_op = kgp_pkg::alu_pass_b;
			end
			kgp_pkg::op_bnz: begin
				ctrl.br     = kgp_pkg::br_bnz;
				ctrl.alu_op = kgp_pkg::alu_pass_b;
			end
			kgp_pkg::op_bcy:  ctrl.br = kgp_pkg::br_bcy;
			kgp_pkg::op_bncy: ctrl.br = kgp_pkg::br_bncy;
			default: ctrl.illegal = 1'b1;
		endcase
	end

	// Decode table must never ask for a load and a store together
	always_comb begin
		assert (!(ctrl.mem_read && ctrl.mem_write))
			else $error("control_unit: mem_read and mem_write both set, instr %h", instr);
	end

endmodule

// ==== verilog/alu.sv ====
`timescale 1ns/100ps

module alu (
	input  kgp_pkg::word_t  a,
	input  kgp_pkg::word_t  b,
	input  kgp_pkg::shamt_t shamt,
	input  kgp_pkg::alu_op_t op,
	output kgp_pkg::word_t  result,
	output kgp_pkg::flags_t flags
);

	logic           is_comp;
	logic           uses_adder;
	kgp_pkg::word_t add_a;
	kgp_pkg::word_t add_b;
	logic [32:0]    sum;

	////////////////////
	// Shared adder
	////////////////////

	// Comp is 0 + ~b + 1 on the same adder
	assign is_comp    = (op == kgp_pkg::alu_comp);
	assign uses_adder = (op == kgp_pkg::alu_add) || is_comp;
	assign add_a      = is_comp ? 32'd0 : a;
	assign add_b      = is_comp ? ~b : b;
	assign sum        = {1'b0, add_a} + {1'b0, add_b} + 33'(is_comp);

	////////////////////
	// Result select
	////////////////////

	always_comb begin
		case (op)
			kgp_pkg::alu_add,
			kgp_pkg::alu_comp:   result = sum[31:0];
			kgp_pkg::alu_and:    result = a & b;
			kgp_pkg::alu_xor:    result = a ^ b;
			kgp_pkg::alu_shll:   result = a << shamt;
			kgp_pkg::alu_shrl:   result = a >> shamt;
			kgp_pkg::alu_shra:   result = kgp_pkg::word_t'($signed(a) >>> shamt);
			kgp_pkg::alu_pass_b: result = b;
			default:             result = '0;
		endcase
	end

	// Carry only means something for add and comp
	assign flags.carry = uses_adder ? sum[32] : 1'b0;
	assign flags.zero  = (result == '0);
	assign flags.sign  = result[31];

endmodule

// ==== verilog/register_file.sv ====
`timescale 1ns/100ps

module register_file (
	input  logic               clk,
	input  logic               arst_n,
	input  kgp_pkg::reg_addr_t rs_addr,
	input  kgp_pkg::reg_addr_t rt_addr,
	input  logic               wr_en,
	input  kgp_pkg::reg_addr_t wr_addr,
	input  kgp_pkg::word_t     wr_data,
	output kgp_pkg::word_t     rs_data,
	output kgp_pkg::word_t     rt_data
);

	kgp_pkg::word_t regs [32];

	// r0 is an ordinary register here
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en) begin
			regs[wr_addr] <= wr_data;
		end
	end

	// Reads are combinational, no write bypass
	assign rs_data = regs[rs_addr];
	assign rt_data = regs[rt_addr];

	// Catches undriven memory data or a bad write-back select upstream
	a_wr_data_known: assert property (
		@(posedge clk) disable iff (!arst_n)
		wr_en |-> !$isunknown(wr_data)
	) else $error("register_file: unknown write data %h to r%0d", wr_data, wr_addr);

endmodule

// ==== verilog/branch_unit.sv ====
`timescale 1ns/100ps

module branch_unit (
	input  logic                clk,
	input  logic                arst_n,
	input  kgp_pkg::br_kind_t   br,
	input  logic                set_carry,
	input  logic [25:0]         target,
	input  kgp_pkg::word_t      rs_data,
	input  kgp_pkg::flags_t     alu_flags,
	output kgp_pkg::word_t      pc,
	output kgp_pkg::word_t      pc_plus4
);

	logic           carry_q;
	logic           taken;
	kgp_pkg::word_t jump_addr;
	kgp_pkg::word_t next_pc;

	assign pc_plus4 = pc + 32'd4;

	////////////////////
	// Next PC
	////////////////////

	always_comb begin
		taken     = 1'b0;
		jump_addr = {4'b0000, target, 2'b00};
		case (br)
			kgp_pkg::br_b,
			kgp_pkg::br_bl: taken = 1'b1;
			kgp_pkg::br_br: begin
				taken     = 1'b1;
				jump_addr = rs_data;
			end
			// rs sits in target[25:21] for these, so only 21 bits remain
			kgp_pkg::br_bltz: begin
				taken     = alu_flags.sign;
				jump_addr = {9'd0, target[20:0], 2'b00};
			end
			kgp_pkg::br_bz: begin
				taken     = alu_flags.zero;
				jump_addr = {9'd0, target[20:0], 2'b00};
			end
			kgp_pkg::br_bnz: begin
				taken     = !alu_flags.zero;
				jump_addr = {9'd0, target[20:0], 2'b00};
			end
			kgp_pkg::br_bcy:  taken = carry_q;
			kgp_pkg::br_bncy: taken = !carry_q;
			default:          taken = 1'b0;
		endcase
	end

	assign next_pc = taken ? jump_addr : pc_plus4;

	// Carry flag survives until the next add, addi, comp or compi
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			pc      <= kgp_pkg::reset_pc;
			carry_q <= 1'b0;
		end else begin
			pc <= next_pc;
			if (set_carry) begin
				carry_q <= alu_flags.carry;
			end
		end
	end

	// A br through a misaligned register value shows up here
	a_pc_aligned: assert property (
		@(posedge clk) disable iff (!arst_n)
		pc[1:0] == 2'b00
	) else $error("branch_unit: misaligned pc %h", pc);

endmodule

// ==== verilog/kgp_core.sv ====
`timescale 1ns/100ps

module kgp_core (
	input  logic           clk,
	input  logic           arst_n,
	output kgp_pkg::word_t instr_addr,
	input  kgp_pkg::word_t instr,
	output kgp_pkg::word_t mem_addr,
	output kgp_pkg::word_t mem_wdata,
	input  kgp_pkg::word_t mem_rdata,
	output logic           mem_read,
	output logic           mem_write
);

	kgp_pkg::ctrl_t     ctrl;
	kgp_pkg::reg_addr_t rs_addr;
	kgp_pkg::reg_addr_t rt_addr;
	kgp_pkg::reg_addr_t wr_addr;
	kgp_pkg::word_t     rs_data;
	kgp_pkg::word_t     rt_data;
	kgp_pkg::word_t     imm_ext;
	kgp_pkg::word_t     alu_b;
	kgp_pkg::word_t     alu_result;
	kgp_pkg::word_t     wr_data;
	kgp_pkg::word_t     pc;
	kgp_pkg::word_t     pc_plus4;
	kgp_pkg::shamt_t    shamt;
	kgp_pkg::flags_t    alu_flags;

	assign rs_addr = instr[25:21];
	assign rt_addr = instr[20:16];
	assign imm_ext = {{16{instr[15]}}, instr[15:0]};

	////////////////////
	// Operand select
	////////////////////

	// Register-tested branches feed rs to the pass-through side
	always_comb begin
		if (ctrl.use_imm) begin
			alu_b = imm_ext;
		end else if (ctrl.alu_op == kgp_pkg::alu_pass_b) begin
			alu_b = rs_data;
		end else begin
			alu_b = rt_data;
		end
	end

	assign shamt = ctrl.shift_by_reg ? rt_data[4:0] : instr[10:6];

	////////////////////
	// Write-back
	////////////////////

	always_comb begin
		case (ctrl.dest)
			kgp_pkg::dest_rt:  wr_addr = rt_addr;
			kgp_pkg::dest_r31: wr_addr = kgp_pkg::link_reg;
			default:           wr_addr = rs_addr;
		endcase
		case (ctrl.wb)
			kgp_pkg::wb_mem:  wr_data = mem_rdata;
			kgp_pkg::wb_link: wr_data = pc_plus4;
			default:          wr_data = alu_result;
		endcase
	end

	assign instr_addr = pc;
	assign mem_addr   = alu_result;
	assign mem_wdata  = rt_data;
	assign mem_read   = ctrl.mem_read;
	// No store leaves the core while reset is held
	assign mem_write  = ctrl.mem_write && arst_n;

	control_unit u_control (
		.instr (instr),
		.ctrl  (ctrl)
	);

	alu u_alu (
		.a      (rs_data),
		.b      (alu_b),
		.shamt  (shamt),
		.op     (ctrl.alu_op),
		.result (alu_result),
		.flags  (alu_flags)
	);

	register_file u_regs (
		.clk     (clk),
		.arst_n  (arst_n),
		.rs_addr (rs_addr),
		.rt_addr (rt_addr),
		.wr_en   (ctrl.reg_write),
		.wr_addr (wr_addr),
		.wr_data (wr_data),
		.rs_data (rs_data),
		.rt_data (rt_data)
	);

	branch_unit u_branch (
		.clk       (clk),
		.arst_n    (arst_n),
		.br        (ctrl.br),
		.set_carry (ctrl.set_carry),
		.target    (instr[25:0]),
		.rs_data   (rs_data),
		.alu_flags (alu_flags),
		.pc        (pc),
		.pc_plus4  (pc_plus4)
	);

endmodule

// ==== tests/kgp_core_tb.sv ====
`timescale 1ns/100ps

module kgp_core_tb;

	// Image layout of the pattern file, in words
	localparam int prog_base  = 'h00;
	localparam int data_base  = 'h40;
	localparam int len_addr   = 'h50;
	localparam int count_addr = 'h51;
	localparam int pair_base  = 'h52;

	// sw r0, 0(r0) fetched during the early part of reset
	localparam kgp_pkg::word_t store_probe = {kgp_pkg::op_sw, 26'd0};

	logic           clk;
	logic           arst_n;
	kgp_pkg::word_t instr_addr;
	kgp_pkg::word_t instr;
	kgp_pkg::word_t mem_addr;
	kgp_pkg::word_t mem_wdata;
	kgp_pkg::word_t mem_rdata;
	logic           mem_read;
	logic           mem_write;

	kgp_pkg::word_t image    [128];
	kgp_pkg::word_t prog     [64];
	kgp_pkg::word_t dmem     [64];
	kgp_pkg::word_t exp_addr [32];
	kgp_pkg::word_t exp_data [32];

	int   errors;
	int   stores_seen;
	int   store_count;
	int   prog_len;
	logic loaded;
	logic first_fetch;
	logic reset_store;

	kgp_core UUT (
		.clk        (clk),
		.arst_n     (arst_n),
		.instr_addr (instr_addr),
		.instr      (instr),
		.mem_addr   (mem_addr),
		.mem_wdata  (mem_wdata),
		.mem_rdata  (mem_rdata),
		.mem_read   (mem_read),
		.mem_write  (mem_write)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#10 clk = ~clk;
		end
	end

	////////////////////
	// Pattern loading
	////////////////////

	task automatic load_patterns();
		for (int i = 0; i < 128; i++) begin
			image[i] = '0;
		end
		$readmemh("tests/kgp_patterns.txt", image);
		for (int i = 0; i < 64; i++) begin
			prog[i] = image[prog_base + i];
			dmem[i] = (i < 16) ? image[data_base + i] : '0;
		end
		prog_len    = int'(image[len_addr]);
		store_count = int'(image[count_addr]);
		for (int i = 0; i < 32; i++) begin
			exp_addr[i] = image[pair_base + 2 * i];
			exp_data[i] = image[pair_base + 2 * i + 1];
		end
	endtask

	////////////////////
	// Memory models
	////////////////////

	// Fetch first, then the load data once mem_addr has settled
	always @(negedge clk) begin
		instr = reset_store ? store_probe : prog[instr_addr[7:2]];
		#2 mem_rdata = dmem[mem_addr[7:2]];
	end

	always @(posedge clk) begin
		if (!arst_n) begin
			assert (!mem_write)
			else begin
				$display("Fail mem_write: expected %h, got %h", 1'b0, mem_write);
				errors++;
			end
			assert (instr_addr == '0)
			else begin
				$display("Fail instr_addr: expected %h, got %h", 32'h0, instr_addr);
				errors++;
			end
		end else begin
			if (first_fetch) begin
				assert (instr_addr == '0)
				else begin
					$display("Fail instr_addr: expected %h, got %h", 32'h0, instr_addr);
					errors++;
				end
				first_fetch = 1'b0;
			end
			// Only a load word asks for read data
			assert (mem_read == (instr[31:26] == kgp_pkg::op_lw))
			else begin
				$display("Fail mem_read: expected %h, got %h",
					instr[31:26] == kgp_pkg::op_lw, mem_read);
				errors++;
			end
			if (mem_write) begin
				dmem[mem_addr[7:2]] = mem_wdata;
				assert (stores_seen < store_count)
				else begin
					$display("Error: store to %h after the last expected store", mem_addr);
					errors++;
				end
				if (stores_seen < store_count) begin
					assert (mem_addr == exp_addr[stores_seen])
					else begin
						$display("Fail mem_addr: expected %h, got %h",
							exp_addr[stores_seen], mem_addr);
						errors++;
					end
					assert (mem_wdata == exp_data[stores_seen])
					else begin
						$display("Fail mem_wdata: expected %h, got %h",
							exp_data[stores_seen], mem_wdata);
						errors++;
					end
				end
				stores_seen++;
			end
		end
	end

	// Limit is 20 cycles per program word plus the reset
	initial begin
		wait (loaded);
		repeat (20 * prog_len + 16) @(posedge clk);
		$display("Error: program never finished, %0d of %0d stores seen",
			stores_seen, store_count);
		$display("Test failed");
		$finish;
	end

	initial begin
		arst_n      = 1'b0;
		instr       = store_probe;
		mem_rdata   = '0;
		reset_store = 1'b1;
		errors      = 0;
		stores_seen = 0;
		first_fetch = 1'b1;
		loaded      = 1'b0;
		load_patterns();
		loaded = 1'b1;
		// A store word sits on the fetch port for the first half of reset
		repeat (8) @(negedge clk);
		reset_store = 1'b0;
		repeat (8) @(negedge clk);
		arst_n = 1'b1;
		wait (stores_seen >= store_count);
		// Let a stray store show up
		repeat (4) @(negedge clk);
		$display("Errors: %0d, stores checked: %0d of %0d", errors, stores_seen, store_count);
		if (errors == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

// ==== tests/kgp_patterns.txt ====
// Program words at @00, data words at @40, program length and store count at @50,
// then expected stores as address and data pairs in program order from @52
@00
0C010000 0C020004 0C03000C 0C040010 05400040
// add, comp, and, xor with stores
00220000 11410000 00A30001 11450004 00640002 11430008 00820003 1144000C
// addi, compi
04C0FFFD 08E00010 11460010 11470014
// Immediate shifts
00600104 11430018 00400086 1142001C 00E00105 11470020
// Variable shifts by r9
05200008 00890007 11440024 00A90009 11450028 00C90008 1146002C
// Negative offset store and reload
05600080 1165FFF8 0D6CFFF8 114C0030
// Carry branches
00220000 30000026 11410034 2C000027 11620000
// bz, bnz, bltz
24000029 11620004 2800002C 11640008 20A0002D 1162000C 20C0002F 11660010
// bl, link store, loop, subroutine with br r31
1C000032 117F0014 18000031 11610018 17E00000
@40
00000005 FFFFFFF0 80000000 12345678 0F0F00FF
@50
00000034 00000013
@52
00000040 FFFFFFF5
00000044 EDCBA988
00000048 02040078
0000004C F0F0FF0F
00000050 FFFFFFFD
00000054 FFFFFFF0
00000058 20400780
0000005C FFFFFFFC
00000060 0FFFFFFF
00000064 F0FF0F00
00000068 FFEDCBA9
0000006C 00FFFFFF
00000078 FFEDCBA9
00000070 FFEDCBA9
00000074 FFFFFFF1
00000088 F0FF0F00
00000090 00FFFFFF
00000098 FFFFFFF1
00000094 000000C0

// ==== kgp_core.f ====
verilog/kgp_pkg.sv
verilog/control_unit.sv
verilog/alu.sv
verilog/register_file.sv
verilog/branch_unit.sv
verilog/kgp_core.sv
tests/kgp_core_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the kgp_core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
	--top-module kgp_core_tb \
	-f kgp_core.f \
	--Mdir obj_dir -o kgp_sim
if [ $? -ne 0 ]; then
	echo "Build failed"
	exit 1
fi

./obj_dir/kgp_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "Test failed" sim.log; then
	exit 1
fi
exit 0
